// File: include/fk_sin_table.svh
// ~~~~~~~~~~~~~~~~~~~~
// quarter-wave sine table
// entry k = round(sin(k*pi/32) * 16384)
// ~~~~~~~~~~~~~~~~~~~~
`ifndef FK_SIN_TABLE_SVH
`define FK_SIN_TABLE_SVH

localparam logic [14:0] SIN_Q [0:16] = '{
	15'd0,
	15'd1606,
	15'd3196,
	15'd4756,
	15'd6270,
	15'd7723,
	15'd9102,
	15'd10394,
	15'd11585,
	15'd12665,
	15'd13623,
	15'd14449,
	15'd15137,
	15'd15679,
	15'd16069,
	15'd16305,
	15'd16384   // 1.0 at a quarter turn
};

`endif

// File: src/fk_kin_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// kinematics package
// Q3.14 fixed-point word and product rule,
// angle index, DH parameter and 4x4 matrix types
// ~~~~~~~~~~~~~~~~~~~~
package fk_kin_pkg;

	localparam int FX_W = 18;       // word width
	localparam int FRAC_BITS = 14;  // fraction bits
	localparam int NUM_JOINTS = 6;

	typedef logic signed [FX_W-1:0] fx_t;
	typedef logic [5:0] ang_t;      // 1/64 turn per step
	typedef logic [2:0] joint_idx_t;

	localparam fx_t ONE_FX = 18'sd16384;

	// one joint, 48 bits
	typedef struct packed {
		ang_t theta;
		ang_t alpha;
		fx_t  a;
		fx_t  d;
	} dh_param_t;

	typedef dh_param_t [NUM_JOINTS-1:0] dh_file_t;

	// row-major, element (r,c) at m[r][c]
	typedef fx_t [3:0][3:0] mat4_t;

	// full product, arithmetic shift, truncate to word
	function automatic fx_t fx_mul(fx_t x, fx_t y);
		logic signed [2*FX_W-1:0] p;
		p = x * y;
		return fx_t'(p >>> FRAC_BITS);
	endfunction

endpackage

// File: src/fk_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// APB register map
// request/response structs, offsets, field codes
// ~~~~~~~~~~~~~~~~~~~~
package fk_reg_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

	localparam logic [7:0] ADDR_DH_BASE  = 8'h00;
	localparam logic [7:0] DH_SPAN       = 8'h60;  // 6 joints x 4 fields x 4 bytes
	localparam logic [7:0] ADDR_CTRL     = 8'h60;
	localparam logic [7:0] ADDR_STATUS   = 8'h64;
	localparam logic [7:0] ADDR_RES_BASE = 8'h80;
	localparam logic [7:0] RES_SPAN      = 8'h40;  // 16 elements

	// field order inside one joint
	localparam logic [1:0] FLD_THETA = 2'd0;
	localparam logic [1:0] FLD_ALPHA = 2'd1;
	localparam logic [1:0] FLD_A     = 2'd2;
	localparam logic [1:0] FLD_D     = 2'd3;

	localparam int CTRL_START_BIT = 0;
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;

endpackage

// File: src/fk_trig_lut.sv
// ~~~~~~~~~~~~~~~~~~~~
// registered sine/cosine lookup
// for one 6-bit angle index
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_trig_lut (
	input  logic             i,
	input  logic             arst_n,
	input  fk_kin_pkg::ang_t ang,
	output fk_kin_pkg::fx_t  sin_o,
	output fk_kin_pkg::fx_t  cos_o
);
	import fk_kin_pkg::*;

	`include "fk_sin_table.svh"

	// quadrant from the top two bits, odd quadrants mirror the offset
	function automatic fx_t sin_of(ang_t x);
		logic [4:0] idx;
		fx_t        mag;
		idx = x[4] ? 5'd16 - {1'b0, x[3:0]} : {1'b0, x[3:0]};
		mag = {3'b000, SIN_Q[idx]};
		return x[5] ? -mag : mag;  // lower half of the turn is negative
	endfunction

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			sin_o <= '0;
			cos_o <= '0;
		end else begin
			sin_o <= sin_of(ang);
			cos_o <= sin_of(ang_t'(ang + ang_t'(16)));  // cos = sin shifted a quarter
		end
	end

endmodule

// File: src/fk_dh_transform.sv
// ~~~~~~~~~~~~~~~~~~~~
// DH transform of one joint
// two-stage pipeline, req to valid in 2 cycles
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_dh_transform (
	input  logic                  i,
	input  logic                  arst_n,
	input  logic                  req,
	input  fk_kin_pkg::dh_param_t param,
	output fk_kin_pkg::mat4_t     mat,
	output logic                  valid
);
	import fk_kin_pkg::*;

	fx_t  st, ct, sa, ca;
	fx_t  a_q, d_q;
	logic req_q;

	fk_trig_lut u_theta_lut (.i, .arst_n, .ang(param.theta), .sin_o(st), .cos_o(ct));
	fk_trig_lut u_alpha_lut (.i, .arst_n, .ang(param.alpha), .sin_o(sa), .cos_o(ca));

	// offsets ride along with the trig stage
	always_ff @(posedge i) begin
		if (req) begin
			a_q <= param.a;
			d_q <= param.d;
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			req_q <= 1'b0;
			valid <= 1'b0;
		end else begin
			req_q <= req;
			valid <= req_q;
		end
	end

	// matrix is held until the next request
	always_ff @(posedge i) begin
		if (req_q) begin
			mat[0] <= {fx_mul(a_q, ct), fx_mul(st, sa), -fx_mul(st, ca), ct};
			mat[1] <= {fx_mul(a_q, st), -fx_mul(ct, sa), fx_mul(ct, ca), st};
			mat[2] <= {d_q, ca, sa, fx_t'(0)};
			mat[3] <= {ONE_FX, fx_t'(0), fx_t'(0), fx_t'(0)};  // homogeneous row
		end
	end

	a_req_to_valid: assert property (@(posedge i) disable iff (!arst_n) req |-> ##2 valid)
		else $error("dh transform: valid did not follow req by 2 cycles");

endmodule

// File: src/fk_mat_mult.sv
// ~~~~~~~~~~~~~~~~~~~~
// sequential 4x4 matrix multiplier
// one result row per cycle, done 5 cycles after start
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_mat_mult (
	input  logic              i,
	input  logic              arst_n,
	input  logic              start,
	input  fk_kin_pkg::mat4_t a,
	input  fk_kin_pkg::mat4_t b,
	output fk_kin_pkg::mat4_t prod,
	output logic              done
);
	import fk_kin_pkg::*;

	mat4_t      a_q, b_q;
	logic       run;
	logic [1:0] row;
	fx_t  [3:0] row_res;

	// four dot products of the current row, sums wrap at 18 bits
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			row_res[c] = '0;
			for (int k = 0; k < 4; k++) begin
				row_res[c] = row_res[c] + fx_mul(a_q[row][k], b_q[k][c]);
			end
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			run  <= 1'b0;
			row  <= '0;
			done <= 1'b0;
		end else begin
			done <= run && (row == 2'd3);  // cycle after the last row
			if (start) begin
				run <= 1'b1;
				row <= '0;
			end else if (run) begin
				row <= row + 2'd1;
				if (row == 2'd3)
					run <= 1'b0;
			end
		end
	end

	always_ff @(posedge i) begin
		if (start) begin
			a_q <= a;
			b_q <= b;
		end
		if (run)
			prod[row] <= row_res;
	end

	a_no_overlap: assert property (@(posedge i) disable iff (!arst_n) start |-> !run)
		else $error("mat mult: start while a product is in progress");

endmodule

// File: src/fk_chain_seq.sv
// ~~~~~~~~~~~~~~~~~~~~
// joint sequencer
// runs the DH transform per joint and folds
// each matrix into the chain product
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_chain_seq (
	input  logic                  i,
	input  logic                  arst_n,
	input  logic                  start,
	input  fk_kin_pkg::dh_file_t  dh_file,
	output logic                  busy,
	output logic                  done,
	output fk_kin_pkg::mat4_t     result,
	output logic                  dh_req,
	output fk_kin_pkg::dh_param_t dh_param,
	input  fk_kin_pkg::mat4_t     dh_mat,
	input  logic                  dh_valid,
	output logic                  mm_start,
	output fk_kin_pkg::mat4_t     mm_a,
	output fk_kin_pkg::mat4_t     mm_b,
	input  fk_kin_pkg::mat4_t     mm_prod,
	input  logic                  mm_done
);
	import fk_kin_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_XFORM, S_MULT} state_t;

	localparam joint_idx_t LAST_JOINT = joint_idx_t'(NUM_JOINTS - 1);

	state_t     state;
	joint_idx_t joint;
	mat4_t      acc;    // running product T0..Tj

	assign busy     = (state != S_IDLE);
	assign dh_param = dh_file[joint];
	assign mm_a     = acc;
	assign mm_b     = dh_mat;  // held by the transform until the next req
	assign result   = acc;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state    <= S_IDLE;
			joint    <= '0;
			dh_req   <= 1'b0;
			mm_start <= 1'b0;
			done     <= 1'b0;
		end else begin
			dh_req   <= 1'b0;
			mm_start <= 1'b0;
			done     <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						joint  <= '0;
						dh_req <= 1'b1;
						state  <= S_XFORM;
					end
				end
				S_XFORM: begin
					if (dh_valid) begin
						if (joint == '0) begin  // first matrix goes straight to acc
							joint  <= joint + 3'd1;
							dh_req <= 1'b1;
						end else begin
							mm_start <= 1'b1;
							state    <= S_MULT;
						end
					end
				end
				S_MULT: begin
					if (mm_done) begin
						if (joint == LAST_JOINT) begin
							done  <= 1'b1;
							state <= S_IDLE;
						end else begin
							joint  <= joint + 3'd1;
							dh_req <= 1'b1;
							state  <= S_XFORM;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state == S_XFORM && dh_valid && joint == '0)
			acc <= dh_mat;
		else if (state == S_MULT && mm_done)
			acc <= mm_prod;
	end

	// a restart would show up as a fresh joint 0 request
	a_start_ignored: assert property (@(posedge i) disable iff (!arst_n)
		start && busy |=> !(dh_req && joint == '0))
		else $error("chain seq: start restarted a running chain");

endmodule

// File: src/fk_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// APB slave
// DH parameter file, control, status,
// sticky done and result readback
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_apb_regs (
	input  logic                 i,
	input  logic                 arst_n,
	input  fk_reg_pkg::apb_req_t apb_req,
	output fk_reg_pkg::apb_rsp_t apb_rsp,
	output fk_kin_pkg::dh_file_t dh_file,
	output logic                 start,
	input  logic                 busy,
	input  logic                 done,
	input  fk_kin_pkg::mat4_t    result
);
	import fk_kin_pkg::*;
	import fk_reg_pkg::*;

	logic        access, aligned, is_dh, is_ctrl, is_stat, is_res, err, wr_ok;
	logic [7:0]  dh_off, res_off;
	joint_idx_t  jsel;
	logic [1:0]  fld;
	logic        done_flag;  // sticky until the next start
	mat4_t       res_q;
	logic [31:0] rdata;

	function automatic logic [31:0] sext(fx_t v);
		return {{(32-FX_W){v[FX_W-1]}}, v};
	endfunction

	assign access  = apb_req.psel && apb_req.penable;
	assign aligned = (apb_req.paddr[1:0] == 2'b00);
	assign dh_off  = apb_req.paddr - ADDR_DH_BASE;
	assign res_off = apb_req.paddr - ADDR_RES_BASE;
	assign jsel    = dh_off[6:4];
	assign fld     = dh_off[3:2];
	assign is_dh   = aligned && (dh_off < DH_SPAN);
	assign is_ctrl = (apb_req.paddr == ADDR_CTRL);
	assign is_stat = (apb_req.paddr == ADDR_STATUS);
	assign is_res  = aligned && (apb_req.paddr >= ADDR_RES_BASE) && (res_off < RES_SPAN);

	always_comb begin
		err = 1'b0;
		if (!(is_dh || is_ctrl || is_stat || is_res))
			err = 1'b1;                                         // unmapped
		else if (apb_req.pwrite && (is_stat || is_res))
			err = 1'b1;                                         // read only
		else if (apb_req.pwrite && busy && (is_dh || is_ctrl))
			err = 1'b1;                                         // locked while running
	end

	assign wr_ok = access && apb_req.pwrite && !err;
	assign start = wr_ok && is_ctrl && apb_req.pwdata[CTRL_START_BIT];

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			dh_file <= '0;
		end else if (wr_ok && is_dh) begin
			case (fld)
				FLD_THETA: dh_file[jsel].theta <= apb_req.pwdata[5:0];
				FLD_ALPHA: dh_file[jsel].alpha <= apb_req.pwdata[5:0];
				FLD_A:     dh_file[jsel].a     <= apb_req.pwdata[FX_W-1:0];
				default:   dh_file[jsel].d     <= apb_req.pwdata[FX_W-1:0];
			endcase
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			done_flag <= 1'b0;
			res_q     <= '0;
		end else begin
			if (start)
				done_flag <= 1'b0;
			else if (done)
				done_flag <= 1'b1;
			if (done)
				res_q <= result;  // snapshot of the finished chain
		end
	end

	always_comb begin
		rdata = '0;
		if (is_dh) begin
			case (fld)
				FLD_THETA: rdata = {26'b0, dh_file[jsel].theta};
				FLD_ALPHA: rdata = {26'b0, dh_file[jsel].alpha};
				FLD_A:     rdata = sext(dh_file[jsel].a);
				default:   rdata = sext(dh_file[jsel].d);
			endcase
		end else if (is_stat) begin
			rdata[STAT_BUSY_BIT] = busy;
			rdata[STAT_DONE_BIT] = done_flag;
		end else if (is_res) begin
			rdata = sext(res_q[res_off[5:4]][res_off[3:2]]);
		end
	end

	assign apb_rsp = '{pready: 1'b1, pslverr: access && err, prdata: rdata};

	// an error can only close a transfer that had its setup phase
	a_err_in_access: assert property (@(posedge i) disable iff (!arst_n)
		apb_rsp.pslverr |-> access && $past(apb_req.psel))
		else $error("apb regs: pslverr outside an access phase");

endmodule

// File: src/fk_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// forward-kinematics engine top
// register block, sequencer, transform, multiplier
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_top (
	input  logic                 i,
	input  logic                 arst_n,
	input  fk_reg_pkg::apb_req_t apb_req,
	output fk_reg_pkg::apb_rsp_t apb_rsp
);
	import fk_kin_pkg::*;

	dh_file_t  dh_file;
	dh_param_t dh_param;
	mat4_t     result, dh_mat, mm_a, mm_b, mm_prod;
	logic      start, busy, done, dh_req, dh_valid, mm_start, mm_done;

	fk_apb_regs u_regs (
		.i, .arst_n, .apb_req, .apb_rsp,
		.dh_file, .start, .busy, .done, .result
	);

	fk_chain_seq u_seq (
		.i, .arst_n, .start, .dh_file, .busy, .done, .result,
		.dh_req, .dh_param, .dh_mat, .dh_valid,
		.mm_start, .mm_a, .mm_b, .mm_prod, .mm_done
	);

	fk_dh_transform u_xform (
		.i, .arst_n, .req(dh_req), .param(dh_param), .mat(dh_mat), .valid(dh_valid)
	);

	fk_mat_mult u_mult (
		.i, .arst_n, .start(mm_start), .a(mm_a), .b(mm_b), .prod(mm_prod), .done(mm_done)
	);

endmodule

// File: tb/fk_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 4 ns clock, reset held for 3 cycles
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_clk_gen (
	output logic i,
	output logic arst_n
);
	initial begin
		i = 1'b0;
		forever #2 i = ~i;  // 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge i);
		@(negedge i);  // release away from the active edge
		arst_n = 1'b1;
	end

endmodule

// File: tb/fk_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// forward-kinematics testbench
// APB tasks, reference model of the DH chain,
// assertions, cycle limit and summary
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fk_tb;
	import fk_kin_pkg::*;
	import fk_reg_pkg::*;

	localparam int MAX_CYCLES = 2000;  // six chains of under 200 cycles each with margin

	logic        i, arst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	int          errors = 0;
	int          cycles = 0;
	integer      seed = 67;
	logic [31:0] rd;
	logic        err;
	int          sin_tab [0:16];
	ang_t        th [0:5];
	ang_t        al [0:5];
	fx_t         la [0:5];
	fx_t         ld [0:5];
	fx_t         exp_m [0:3][0:3];  // expected chain product

	fk_clk_gen u_clk (.i, .arst_n);

	fk_top i_dut (.i, .arst_n, .apb_req, .apb_rsp);

	a_pready: assert property (@(posedge i) disable iff (!arst_n) apb_rsp.pready)
		else begin
			errors++;
			$display("pready dropped to 0");
		end

	// accepted start write, busy in the next cycle
	a_busy_rise: assert property (@(posedge i) disable iff (!arst_n)
		apb_req.psel && apb_req.penable && apb_req.pwrite && (apb_req.paddr == ADDR_CTRL)
		&& apb_req.pwdata[CTRL_START_BIT] && !apb_rsp.pslverr |=> $rose(i_dut.busy))
		else begin
			errors++;
			$display("busy did not rise in the cycle after the start write");
		end

	a_latency: assert property (@(posedge i) disable iff (!arst_n)
		$rose(i_dut.busy) |-> ##48 i_dut.done)
		else begin
			errors++;
			$display("done pulse did not come 48 cycles after busy rose");
		end

	a_done_sticky: assert property (@(posedge i) disable iff (!arst_n)
		$fell(i_dut.busy) |=> i_dut.u_regs.done_flag)
		else begin
			errors++;
			$display("done flag was not set after busy fell");
		end

	always @(posedge i) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// one transfer with setup, access and idle phases
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		@(negedge i);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge i);
		apb_req.penable = 1'b1;
		#1;
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge i);
		apb_req = '0;
	endtask

	task automatic write_ok(input string name, input logic [7:0] addr, input logic [31:0] data);
		apb_xfer(1'b1, addr, data, rd, err);
		check_eq({name, " pslverr"}, 32'd0, {31'd0, err});
	endtask

	function automatic logic [7:0] dh_addr(int j, int f);
		return ADDR_DH_BASE + 8'((j * 4 + f) * 4);
	endfunction

	function automatic logic [7:0] res_addr(int r, int c);
		return ADDR_RES_BASE + 8'((r * 4 + c) * 4);
	endfunction

	function automatic fx_t fxmul(fx_t x, fx_t y);
		longint p;
		p = longint'(x) * longint'(y);
		return fx_t'(p >>> FRAC_BITS);  // shift then keep 18 bits
	endfunction

	// quarter-wave symmetry over the 17-entry table
	function automatic fx_t sin_ref(ang_t n);
		int q;
		int off;
		int v;
		q   = int'(n) / 16;
		off = int'(n) % 16;
		v   = (q % 2 == 1) ? sin_tab[16 - off] : sin_tab[off];
		return fx_t'((q >= 2) ? -v : v);
	endfunction

	task automatic build_model();
		fx_t t [0:3][0:3];
		fx_t p [0:3][0:3];
		fx_t st, ct, sa, ca, s;
		for (int j = 0; j < NUM_JOINTS; j++) begin
			st = sin_ref(th[j]);
			ct = sin_ref(ang_t'(th[j] + 16));
			sa = sin_ref(al[j]);
			ca = sin_ref(ang_t'(al[j] + 16));
			t[0] = '{ct, -fxmul(st, ca), fxmul(st, sa), fxmul(la[j], ct)};
			t[1] = '{st, fxmul(ct, ca), -fxmul(ct, sa), fxmul(la[j], st)};
			t[2] = '{fx_t'(0), sa, ca, ld[j]};
			t[3] = '{fx_t'(0), fx_t'(0), fx_t'(0), ONE_FX};
			if (j == 0) begin
				exp_m = t;
			end else begin
				for (int r = 0; r < 4; r++) begin
					for (int c = 0; c < 4; c++) begin
						s = '0;
						for (int k = 0; k < 4; k++)
							s = s + fxmul(exp_m[r][k], t[k][c]);  // wraps at 18 bits
						p[r][c] = s;
					end
				end
				exp_m = p;
			end
		end
	endtask

	task automatic load_params();
		for (int j = 0; j < NUM_JOINTS; j++) begin
			write_ok("dh theta", dh_addr(j, 0), {26'd0, th[j]});
			write_ok("dh alpha", dh_addr(j, 1), {26'd0, al[j]});
			write_ok("dh a", dh_addr(j, 2), 32'(la[j]));
			write_ok("dh d", dh_addr(j, 3), 32'(ld[j]));
		end
	endtask

	task automatic wait_done(input string name);
		do begin
			apb_xfer(1'b0, ADDR_STATUS, 32'd0, rd, err);
		end while (!rd[STAT_DONE_BIT]);
		check_eq({name, " busy at done"}, 32'd0, {31'd0, rd[STAT_BUSY_BIT]});
	endtask

	task automatic check_results(input string name);
		build_model();
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				apb_xfer(1'b0, res_addr(r, c), 32'd0, rd, err);
				check_eq($sformatf("%s (%0d,%0d)", name, r, c), 32'(exp_m[r][c]), rd);
			end
		end
	endtask

	task automatic clear_params();
		for (int j = 0; j < NUM_JOINTS; j++) begin
			th[j] = '0;
			al[j] = '0;
			la[j] = '0;
			ld[j] = '0;
		end
	endtask

	initial begin
		apb_req = '0;
		for (int k = 0; k <= 16; k++)
			sin_tab[k] = $rtoi($floor($sin(k * 3.141592653589793 / 32.0) * 16384.0 + 0.5));
		wait (arst_n === 1'b1);

		// reset state
		apb_xfer(1'b0, ADDR_STATUS, 32'd0, rd, err);
		check_eq("reset status", 32'd0, rd);
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				apb_xfer(1'b0, res_addr(r, c), 32'd0, rd, err);
				check_eq($sformatf("reset result (%0d,%0d)", r, c), 32'd0, rd);
			end
		end

		clear_params();
		load_params();
		write_ok("identity start", ADDR_CTRL, 32'd1);
		wait_done("identity");
		check_results("identity");

		th[0] = 6'd16;  // quarter turn
		la[0] = ONE_FX;
		load_params();
		write_ok("known start", ADDR_CTRL, 32'd1);
		wait_done("known");
		check_results("known");
		apb_xfer(1'b0, res_addr(1, 3), 32'd0, rd, err);
		check_eq("known (1,3) value", 32'd16384, rd);

		for (int n = 0; n < 3; n++) begin
			for (int j = 0; j < NUM_JOINTS; j++) begin
				th[j] = 6'($random(seed));
				al[j] = 6'($random(seed));
				la[j] = fx_t'($random(seed) % 32768);  // within +-2.0
				ld[j] = fx_t'($random(seed) % 32768);
			end
			load_params();
			write_ok($sformatf("random %0d start", n), ADDR_CTRL, 32'd1);
			wait_done($sformatf("random %0d", n));
			check_results($sformatf("random %0d", n));
		end

		// protocol errors
		apb_xfer(1'b0, 8'h70, 32'd0, rd, err);
		check_eq("unmapped read pslverr", 32'd1, {31'd0, err});
		apb_xfer(1'b1, ADDR_STATUS, 32'h3, rd, err);
		check_eq("status write pslverr", 32'd1, {31'd0, err});
		write_ok("protocol start", ADDR_CTRL, 32'd1);
		apb_xfer(1'b1, dh_addr(2, 0), {26'd0, ~th[2]}, rd, err);
		check_eq("busy dh write pslverr", 32'd1, {31'd0, err});
		apb_xfer(1'b1, ADDR_CTRL, 32'd1, rd, err);
		check_eq("busy start pslverr", 32'd1, {31'd0, err});
		wait_done("protocol");
		apb_xfer(1'b0, dh_addr(2, 0), 32'd0, rd, err);
		check_eq("dh file after busy write", {26'd0, th[2]}, rd);
		check_results("protocol");

		$display("summary: %0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
src/fk_kin_pkg.sv
src/fk_reg_pkg.sv
src/fk_trig_lut.sv
src/fk_dh_transform.sv
src/fk_mat_mult.sv
src/fk_chain_seq.sv
src/fk_apb_regs.sv
src/fk_top.sv
tb/fk_clk_gen.sv
tb/fk_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the forward-kinematics testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fk_tb -f src.f -o fk_sim

./obj_dir/fk_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
